// File: rtl/video_ts_pkg.sv
`default_nettype none

package video_ts_pkg;

    // ts-line address, also the sprite x coordinate
    typedef logic [8:0] ts_addr_t;

    // ts-line entry is palette over pixel
    typedef logic [7:0] ts_data_t;

    // one 4-bit pixel index
    typedef logic [3:0] pix_t;

    // palette selector, upper nibble of the color index
    typedef logic [3:0] pal_t;

    // word address into dram
    // page[7:3], line, dword, word bit from msb down
    typedef logic [20:0] dram_addr_t;

    typedef logic [15:0] dram_data_t;

    // four phases of one dram cycle
    typedef enum logic [1:0] {c0, c1, c2, c3} dram_phase_t;

endpackage

`default_nettype wire

// File: rtl/ts_task_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ts_task_queue
#(
    parameter int TASK_DEPTH = 4
)
(
    input  wire                             clk,
    input  wire                             reset,

    // push side
    input  wire                             push,
    input  wire  [7:0]                      push_page,
    input  wire  [8:0]                      push_line,
    input  wire  [5:0]                      push_addr,
    input  wire  video_ts_pkg::ts_addr_t    push_x_coord,
    input  wire  [2:0]                      push_x_size,
    input  wire                             push_flip,
    input  wire  video_ts_pkg::pal_t        push_pal,
    output logic                            full,

    // renderer side
    input  wire                             mem_rdy,
    input  wire                             slot_c2,
    output logic                            tsr_go,
    output logic [7:0]                      head_page,
    output logic [8:0]                      head_line,
    output logic [5:0]                      head_addr,
    output video_ts_pkg::ts_addr_t          head_x_coord,
    output logic [2:0]                      head_x_size,
    output logic                            head_flip,
    output video_ts_pkg::pal_t              head_pal,

    output logic                            idle
);

    localparam int PTR_W  = (TASK_DEPTH > 1) ? $clog2(TASK_DEPTH) : 1;
    localparam int CNT_W  = $clog2(TASK_DEPTH + 1);
    localparam int TASK_W = 40;

    logic [TASK_W-1:0]  fifo_mem [TASK_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               empty;
    logic               do_push;
    logic [2:0]         drain_cnt;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(TASK_DEPTH));

    // push into a full queue is lost
    assign do_push = push && !full;

    // launch only in the c2 slot so the renderer meets its grant
    assign tsr_go = !empty && mem_rdy && slot_c2;

    // storage, no reset
    always_ff @(posedge clk)
    begin
        if (do_push)
            fifo_mem[wr_ptr] <= {push_page, push_line, push_addr, push_x_coord,
                                 push_x_size, push_flip, push_pal};
    end

    assign {head_page, head_line, head_addr, head_x_coord,
            head_x_size, head_flip, head_pal} = fifo_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(TASK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (tsr_go)
                rd_ptr <= (rd_ptr == PTR_W'(TASK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else
            case ({do_push, tsr_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
    end

    // mem_rdy rises four pixels early
    // wait for the last word to drain into the line
    always_ff @(posedge clk)
    begin
        if (reset)
            drain_cnt <= 3'd4;
        else if (!mem_rdy || tsr_go)
            drain_cnt <= 3'd0;
        else if (drain_cnt != 3'd4)
            drain_cnt <= drain_cnt + 3'd1;
    end

    assign idle = empty && mem_rdy && (drain_cnt == 3'd4);

endmodule

`default_nettype wire

// File: rtl/ts_dram_cycle.sv
`timescale 1ns/1ps
`default_nettype none

module ts_dram_cycle
(
    input  wire                             clk,
    input  wire                             reset,

    // renderer side
    input  wire                             dram_req,
    input  wire  video_ts_pkg::dram_addr_t  dram_addr,
    output logic                            dram_pre_next,
    output logic                            dram_next,
    output video_ts_pkg::dram_data_t        dram_rdata,
    output logic                            slot_c2,

    // external memory
    output video_ts_pkg::dram_addr_t        mem_addr,
    output logic                            mem_rd,
    input  wire  video_ts_pkg::dram_data_t  mem_rdata
);

    video_ts_pkg::dram_phase_t  phase;
    logic                       grant;
    logic                       cyc_rd;

    // free running phase counter
    always_ff @(posedge clk)
    begin
        if (reset)
            phase <= video_ts_pkg::c0;
        else
            case (phase)
                video_ts_pkg::c0: phase <= video_ts_pkg::c1;
                video_ts_pkg::c1: phase <= video_ts_pkg::c2;
                video_ts_pkg::c2: phase <= video_ts_pkg::c3;
                default:          phase <= video_ts_pkg::c0;
            endcase
    end

    // request sampled at c3 owns the next cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            grant <= 1'b0;
        else if (phase == video_ts_pkg::c3)
            grant <= dram_req;
    end

    // read strobe at c1, data back at c2
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cyc_rd    <= 1'b0;
            dram_next <= 1'b0;
        end
        else
        begin
            cyc_rd    <= grant && (phase == video_ts_pkg::c0);
            dram_next <= cyc_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant && (phase == video_ts_pkg::c0))
            mem_addr <= dram_addr;
    end

    assign mem_rd        = cyc_rd;
    assign dram_pre_next = cyc_rd;
    assign dram_rdata    = mem_rdata;

    // task launch slot for the queue
    assign slot_c2 = (phase == video_ts_pkg::c2);

endmodule

`default_nettype wire

// File: rtl/video_ts_render.sv
`timescale 1ns/1ps
`default_nettype none

module video_ts_render
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             line_start,

    // task fields, only sampled with tsr_go
    input  wire  video_ts_pkg::ts_addr_t    x_coord,
    input  wire  [2:0]                      x_size,
    input  wire                             flip,
    input  wire                             tsr_go,
    input  wire  [5:0]                      addr,
    input  wire  [8:0]                      line,
    input  wire  [7:0]                      page,
    input  wire  video_ts_pkg::pal_t        pal,
    output logic                            mem_rdy,

    // ts-line write port
    output video_ts_pkg::ts_addr_t          ts_waddr,
    output video_ts_pkg::ts_data_t          ts_wdata,
    output logic                            ts_we,

    // dram side
    output video_ts_pkg::dram_addr_t        dram_addr,
    output logic                            dram_req,
    input  wire  video_ts_pkg::dram_data_t  dram_rdata,
    input  wire                             dram_pre_next,
    input  wire                             dram_next
);

    logic                       rst;
    logic [4:0]                 cyc;
    logic                       pre_next_ok;
    logic [13:0]                addr_offset;
    video_ts_pkg::dram_addr_t   addr_in;
    video_ts_pkg::dram_addr_t   addr_next;
    video_ts_pkg::dram_addr_t   addr_reg;
    logic [11:0]                data_hold;
    logic [2:0]                 cnt;
    logic                       render_on;
    logic                       tsr_rld;
    logic                       tsr_rld_stb;
    video_ts_pkg::ts_addr_t     x_coord_d;
    video_ts_pkg::pal_t         pal_d;
    logic                       flip_d;
    video_ts_pkg::pal_t         pal_r;
    logic                       flip_r;
    video_ts_pkg::ts_addr_t     ts_waddr_mx;
    video_ts_pkg::ts_addr_t     x_next;
    video_ts_pkg::pix_t         pix;
    video_ts_pkg::pix_t         pix_m [0:3];

    // line start kills the task in flight
    assign rst = reset || line_start;

    // keep asking while a task is loaded
    assign dram_req = tsr_go || !mem_rdy;

    // only page bits 7:3 reach the address
    assign addr_offset = {page[7:3], line};
    assign addr_in     = {addr_offset, addr, 1'b0};

    // renderer stays inside one bitmap line, so only the low 7 bits count
    assign addr_next = {addr_reg[20:7], addr_reg[6:0] + {6'd0, dram_next}};
    assign dram_addr = tsr_go ? addr_in : addr_next;

    always_ff @(posedge clk)
    begin
        addr_reg <= dram_addr;
    end

    // stray grants after an abort are ignored
    assign pre_next_ok = dram_pre_next && !mem_rdy;

    // dram cycle counter
    // two words per 8 pixels, wraps to 5'h1f after the last one
    assign mem_rdy = cyc[4];

    always_ff @(posedge clk)
    begin
        if (rst)
            cyc <= 5'b10000;
        else if (tsr_go)
            cyc <= {1'b0, x_size, 1'b1};
        else if (pre_next_ok)
            cyc <= cyc - 5'd1;
    end

    // hold the three late nibbles of the word
    always_ff @(posedge clk)
    begin
        if (dram_next)
            data_hold <= {dram_rdata[3:0], dram_rdata[15:8]};
    end

    // pixel counter, 4 means stopped
    assign render_on = !cnt[2];

    always_ff @(posedge clk)
    begin
        if (rst)
            cnt <= 3'b100;
        else if (pre_next_ok)
            cnt <= 3'b000;
        else if (render_on)
            cnt <= cnt + 3'd1;
    end

    // new task waits for its first granted cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            tsr_rld <= 1'b0;
        else if (tsr_go)
            tsr_rld <= 1'b1;
        else if (pre_next_ok)
            tsr_rld <= 1'b0;
    end

    assign tsr_rld_stb = tsr_rld && pre_next_ok;

    // flipped sprites start at the far end
    always_ff @(posedge clk)
    begin
        if (tsr_go)
        begin
            x_coord_d <= x_coord + (flip ? {3'b000, x_size, 3'b111} : 9'd0);
            pal_d     <= pal;
            flip_d    <= flip;
        end
    end

    // previous task keeps its palette up to its last pixel
    always_ff @(posedge clk)
    begin
        if (tsr_rld_stb)
        begin
            pal_r  <= pal_d;
            flip_r <= flip_d;
        end
    end

    // +1 or -1 per pixel
    assign x_next = ts_waddr + {{8{flip_r}}, 1'b1};

    always_comb
    begin
        if (tsr_rld_stb)
            ts_waddr_mx = x_coord_d;
        else if (render_on)
            ts_waddr_mx = x_next;
        else
            ts_waddr_mx = ts_waddr;
    end

    always_ff @(posedge clk)
    begin
        ts_waddr <= ts_waddr_mx;
    end

    // first pixel comes straight off the bus
    assign pix_m[0] = dram_rdata[7:4];
    assign pix_m[1] = data_hold[11:8];
    assign pix_m[2] = data_hold[7:4];
    assign pix_m[3] = data_hold[3:0];

    assign pix = pix_m[cnt[1:0]];

    // zero pixel is transparent
    assign ts_we    = render_on && |pix;
    assign ts_wdata = {pal_r, pix};

endmodule

`default_nettype wire

// File: rtl/ts_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

module ts_line_buf
(
    input  wire                             clk,

    // renderer write port
    input  wire  video_ts_pkg::ts_addr_t    ts_waddr,
    input  wire  video_ts_pkg::ts_data_t    ts_wdata,
    input  wire                             ts_we,

    // scan-out port
    input  wire  video_ts_pkg::ts_addr_t    rd_addr,
    input  wire                             rd_en,
    output video_ts_pkg::ts_data_t          rd_data
);

    localparam int DEPTH = 512;

    video_ts_pkg::ts_data_t mem [0:DEPTH-1];

    // line starts out blank
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = '0;
        end
    end

    // scan read blanks the entry for the next line
    // clear wins over a write to the same entry
    always_ff @(posedge clk)
    begin
        if (ts_we)
            mem[ts_waddr] <= ts_wdata;
        if (rd_en)
        begin
            rd_data      <= mem[rd_addr];
            mem[rd_addr] <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_ts.sv
`timescale 1ns/1ps
`default_nettype none

module video_ts
#(
    parameter int TASK_DEPTH = 4
)
(
    input  wire                             clk,
    input  wire                             reset,

    // task push
    input  wire                             push,
    input  wire  [7:0]                      page,
    input  wire  [8:0]                      line,
    input  wire  [5:0]                      addr,
    input  wire  video_ts_pkg::ts_addr_t    x_coord,
    input  wire  [2:0]                      x_size,
    input  wire                             flip,
    input  wire  video_ts_pkg::pal_t        pal,
    output wire                             full,

    // external memory
    output wire  video_ts_pkg::dram_addr_t  mem_addr,
    output wire                             mem_rd,
    input  wire  video_ts_pkg::dram_data_t  mem_rdata,

    // line side
    input  wire                             line_start,
    input  wire  video_ts_pkg::ts_addr_t    rd_addr,
    input  wire                             rd_en,
    output wire  video_ts_pkg::ts_data_t    rd_data,

    output wire                             idle
);

    // queue to renderer
    wire                            tsr_go;
    wire                            mem_rdy;
    wire [7:0]                      task_page;
    wire [8:0]                      task_line;
    wire [5:0]                      task_addr;
    wire video_ts_pkg::ts_addr_t    task_x_coord;
    wire [2:0]                      task_x_size;
    wire                            task_flip;
    wire video_ts_pkg::pal_t        task_pal;

    // sequencer
    wire                            slot_c2;
    wire                            dram_req;
    wire video_ts_pkg::dram_addr_t  dram_addr;
    wire                            dram_pre_next;
    wire                            dram_next;
    wire video_ts_pkg::dram_data_t  dram_rdata;

    // pixel writes
    wire video_ts_pkg::ts_addr_t    ts_waddr;
    wire video_ts_pkg::ts_data_t    ts_wdata;
    wire                            ts_we;

    ts_task_queue #(
        .TASK_DEPTH (TASK_DEPTH)
    ) u_queue (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .push_page    (page),
        .push_line    (line),
        .push_addr    (addr),
        .push_x_coord (x_coord),
        .push_x_size  (x_size),
        .push_flip    (flip),
        .push_pal     (pal),
        .full         (full),
        .mem_rdy      (mem_rdy),
        .slot_c2      (slot_c2),
        .tsr_go       (tsr_go),
        .head_page    (task_page),
        .head_line    (task_line),
        .head_addr    (task_addr),
        .head_x_coord (task_x_coord),
        .head_x_size  (task_x_size),
        .head_flip    (task_flip),
        .head_pal     (task_pal),
        .idle         (idle)
    );

    ts_dram_cycle u_dram (
        .clk           (clk),
        .reset         (reset),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next),
        .dram_rdata    (dram_rdata),
        .slot_c2       (slot_c2),
        .mem_addr      (mem_addr),
        .mem_rd        (mem_rd),
        .mem_rdata     (mem_rdata)
    );

    video_ts_render u_render (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .x_coord       (task_x_coord),
        .x_size        (task_x_size),
        .flip          (task_flip),
        .tsr_go        (tsr_go),
        .addr          (task_addr),
        .line          (task_line),
        .page          (task_page),
        .pal           (task_pal),
        .mem_rdy       (mem_rdy),
        .ts_waddr      (ts_waddr),
        .ts_wdata      (ts_wdata),
        .ts_we         (ts_we),
        .dram_addr     (dram_addr),
        .dram_req      (dram_req),
        .dram_rdata    (dram_rdata),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next)
    );

    ts_line_buf u_line (
        .clk      (clk),
        .ts_waddr (ts_waddr),
        .ts_wdata (ts_wdata),
        .ts_we    (ts_we),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_video_ts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_ts;

    // word offsets into the golden image
    localparam int TEST_BASE  = 'h40;
    localparam int TASK_BASE  = 'h48;
    localparam int PAIR_BASE  = 'h80;
    localparam int TASK_WORDS = 7;
    localparam int NUM_TESTS  = 4;
    localparam int LINE_LEN   = 512;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           push;
    logic [7:0]                     page;
    logic [8:0]                     line;
    logic [5:0]                     addr;
    video_ts_pkg::ts_addr_t         x_coord;
    logic [2:0]                     x_size;
    logic                           flip;
    video_ts_pkg::pal_t             pal;
    wire                            full;
    wire video_ts_pkg::dram_addr_t  mem_addr;
    wire                            mem_rd;
    video_ts_pkg::dram_data_t       mem_rdata = '0;
    logic                           line_start;
    video_ts_pkg::ts_addr_t         rd_addr;
    logic                           rd_en;
    wire video_ts_pkg::ts_data_t    rd_data;
    wire                            idle;

    // memory image, test table, task records, expected pairs
    logic [15:0]                golden [0:511];
    video_ts_pkg::dram_addr_t   exp_addr_q [$];

    int check_count  = 0;
    int error_count  = 0;
    int clk_count    = 0;
    int rd_count     = 0;
    int first_rd_clk = 0;
    int last_rd_clk  = 0;
    int task_idx     = 0;
    int pair_idx     = 0;

    video_ts #(
        .TASK_DEPTH (4)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .page       (page),
        .line       (line),
        .addr       (addr),
        .x_coord    (x_coord),
        .x_size     (x_size),
        .flip       (flip),
        .pal        (pal),
        .full       (full),
        .mem_addr   (mem_addr),
        .mem_rd     (mem_rd),
        .mem_rdata  (mem_rdata),
        .line_start (line_start),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .idle       (idle)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    function automatic void compare(input string what, input logic [31:0] got,
                                    input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "unflipped sprite";
            1:       return "flipped sprite";
            2:       return "transparent overlap";
            default: return "back-to-back tasks";
        endcase
    endfunction

    // dram model
    // image indexed by the low address bits
    // word comes back one clock after mem_rd
    always @(posedge clk)
    begin
        clk_count = clk_count + 1;
        if (mem_rd)
        begin
            mem_rdata <= golden[mem_addr[5:0]];
            if (rd_count == 0)
                first_rd_clk = clk_count;
            last_rd_clk = clk_count;
            rd_count = rd_count + 1;
            if (exp_addr_q.size() == 0)
            begin
                check_count++;
                error_count++;
                $display("memory read at %0t with no task left to serve, address %06h",
                         $time, mem_addr);
            end
            else
                compare("memory address", mem_addr, exp_addr_q.pop_front());
        end
    end

    // one task record onto the push port
    task automatic push_task(input int base);
        logic [7:0]                 pg;
        logic [8:0]                 ln;
        logic [5:0]                 ad;
        logic [2:0]                 sz;
        int                         n_words;
        video_ts_pkg::dram_addr_t   first;
        pg = golden[base][7:0];
        ln = golden[base + 1][8:0];
        ad = golden[base + 2][5:0];
        sz = golden[base + 4][2:0];
        @(posedge clk);
        push    <= 1'b1;
        page    <= pg;
        line    <= ln;
        addr    <= ad;
        x_coord <= golden[base + 3][8:0];
        x_size  <= sz;
        flip    <= golden[base + 5][0];
        pal     <= golden[base + 6][3:0];
        // page bits 7:3, line, dword, word bit
        // two words per eight pixels
        // address steps by one per word
        first   = {pg[7:3], ln, ad, 1'b0};
        n_words = 2 * (int'(sz) + 1);
        for (int c = 0; c < n_words; c++)
            exp_addr_q.push_back(first + video_ts_pkg::dram_addr_t'(c));
    endtask

    task automatic wait_idle;
        @(negedge clk);
        while (!idle)
            @(negedge clk);
    endtask

    // data shows up one clock after rd_en
    task automatic read_entry(input video_ts_pkg::ts_addr_t a,
                              output video_ts_pkg::ts_data_t d);
        @(posedge clk);
        rd_addr <= a;
        rd_en   <= 1'b1;
        @(posedge clk);
        rd_en   <= 1'b0;
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic run_test(input int t);
        int                         n_tasks;
        int                         n_pairs;
        int                         exp_cycles;
        int                         checks_before;
        int                         errors_before;
        int                         p;
        video_ts_pkg::ts_addr_t     a;
        video_ts_pkg::ts_data_t     d;
        n_tasks       = golden[TEST_BASE + 2 * t];
        n_pairs       = golden[TEST_BASE + 2 * t + 1];
        checks_before = check_count;
        errors_before = error_count;
        exp_cycles    = 0;
        rd_count      = 0;
        for (int i = 0; i < n_tasks; i++)
        begin
            p = TASK_BASE + TASK_WORDS * (task_idx + i);
            push_task(p);
            exp_cycles += 2 * (int'(golden[p + 4]) + 1);
        end
        @(posedge clk);
        push <= 1'b0;
        wait_idle();
        compare("dram cycle count", rd_count, exp_cycles);
        compare("unread task addresses", exp_addr_q.size(), 0);
        // queued tasks follow each other with no idle dram cycle
        compare("dram cycle span", last_rd_clk - first_rd_clk, 4 * (exp_cycles - 1));
        for (int i = 0; i < n_pairs; i++)
        begin
            p = PAIR_BASE + 2 * (pair_idx + i);
            a = golden[p][8:0];
            read_entry(a, d);
            compare($sformatf("entry %03h", a), d, golden[p + 1][7:0]);
        end
        // first read blanked them
        for (int i = 0; i < n_pairs; i++)
        begin
            a = golden[PAIR_BASE + 2 * (pair_idx + i)][8:0];
            read_entry(a, d);
            compare($sformatf("entry %03h on second read", a), d, 0);
        end
        task_idx += n_tasks;
        pair_idx += n_pairs;
        $display("test %0d, %s: %0d checks, %0d errors", t + 1, test_name(t),
                 check_count - checks_before, error_count - errors_before);
    endtask

    initial
    begin
        int                         total_pairs;
        int                         checks_before;
        int                         errors_before;
        video_ts_pkg::ts_data_t     d;
        reset      = 1'b1;
        push       = 1'b0;
        page       = '0;
        line       = '0;
        addr       = '0;
        x_coord    = '0;
        x_size     = '0;
        flip       = 1'b0;
        pal        = '0;
        line_start = 1'b0;
        rd_addr    = '0;
        rd_en      = 1'b0;
        $readmemh("bench/video_ts_golden.txt", golden);
        total_pairs = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            total_pairs += golden[TEST_BASE + 2 * t + 1];
        if (total_pairs == 0)
        begin
            error_count++;
            $display("golden file bench/video_ts_golden.txt holds no test data");
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checks_before = check_count;
        errors_before = error_count;
        compare("idle after reset", idle, 1);
        compare("full after reset", full, 0);
        compare("mem_rd after reset", mem_rd, 0);
        $display("test 0, reset values: %0d checks, %0d errors",
                 check_count - checks_before, error_count - errors_before);

        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);

        // every written entry was read once so the whole line is blank
        checks_before = check_count;
        errors_before = error_count;
        for (int i = 0; i < LINE_LEN; i++)
        begin
            read_entry(video_ts_pkg::ts_addr_t'(i), d);
            compare($sformatf("blank entry %03h", i), d, 0);
        end
        $display("test %0d, blank line sweep: %0d checks, %0d errors", NUM_TESTS + 1,
                 check_count - checks_before, error_count - errors_before);

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // 200 clocks per task plus 2000
    initial
    begin
        int n_tasks;
        int limit;
        @(posedge clk);
        n_tasks = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            n_tasks += golden[TEST_BASE + 2 * t];
        limit = 200 * n_tasks + 2000;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d clocks, the run did not finish", limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/video_ts_golden.txt
// @000 memory image, 64 words | @040 per test: task count, pair count
// @048 tasks: page line addr x_coord x_size flip pal | @080 pairs: line address, entry
@000
C3A5 9BE7 4812 36F7 6587 2143 0A09 0CB0 DCFE 98BA 5A0A 5A0B 5A0C 5A0D 5A0E 5A0F
3412 7856 BC9A F1DE 4523 8967 CDAB 12EF 5634 9A78 DEBC 23F1 6745 AB89 EFCD 3412
5A20 5A21 5A22 5A23 5A24 5A25 5A26 5A27 5A28 5A29 5A2A 5A2B 5A2C 5A2D 5A2E 5A2F
5A30 5A31 5A32 5A33 5A34 5A35 5A36 5A37 5A38 5A39 5A3A 5A3B 5A3C 5A3D 5A3E 5A3F
@040
1 08  1 08  2 0C  2 48
@048
A8 023 00 010 0 0 3
50 101 01 040 0 1 5
18 0F0 02 080 0 0 2
18 0F0 03 084 0 0 7
F8 1FF 04 100 0 0 1
F8 1FF 08 110 7 0 9
@080
010 3A 011 35 012 3C 013 33 014 3E 015 37 016 39 017 3B
047 51 046 52 045 54 044 58 043 5F 042 57 041 53 040 56
080 28 081 27 082 26 083 25 084 24 085 79 086 22 087 7A
088 7B 089 00 08A 00 08B 7C 100 1F 101 1E 102 1D 103 1C
104 1B 105 1A 106 19 107 18 110 91 111 92 112 93 113 94
114 95 115 96 116 97 117 98 118 99 119 9A 11A 9B 11B 9C
11C 9D 11D 9E 11E 9F 11F 91 120 92 121 93 122 94 123 95
124 96 125 97 126 98 127 99 128 9A 129 9B 12A 9C 12B 9D
12C 9E 12D 9F 12E 91 12F 92 130 93 131 94 132 95 133 96
134 97 135 98 136 99 137 9A 138 9B 139 9C 13A 9D 13B 9E
13C 9F 13D 91 13E 92 13F 93 140 94 141 95 142 96 143 97
144 98 145 99 146 9A 147 9B 148 9C 149 9D 14A 9E 14B 9F
14C 91 14D 92 14E 93 14F 94

// File: compile.f
rtl/video_ts_pkg.sv
rtl/ts_task_queue.sv
rtl/ts_dram_cycle.sv
rtl/video_ts_render.sv
rtl/ts_line_buf.sv
rtl/video_ts.sv
bench/tb_video_ts.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the video_ts testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_video_ts \
        -o sim_video_ts; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_video_ts)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
